// File: hdl/mlpCore_params.svh
`ifndef MLP_CORE_PARAMS_SVH
`define MLP_CORE_PARAMS_SVH

// sample format is signed q8.8.
`define MLP_DATA_W 16
`define MLP_FRAC 8
`define MLP_ACC_W 32

// layer sizes.
`define MLP_N_IN 10
`define MLP_N_HID 4
`define MLP_N_OUT 3

// registers from inValid to outValid in one dense layer.
`define MLP_LAYER_LAT 3

// Tables are concatenations, so the first word is the most significant one.
// Hidden weights run from row 3, input 9 down to row 0, input 0.
`define MLP_HID_WEIGHTS { \
	16'sh015C, 16'sh006A, 16'sh03E0, 16'sh007D, 16'sh00A7, \
	16'shFEE4, 16'shFFD9, 16'shFF37, 16'sh027C, 16'sh0356, \
	16'shFF80, 16'sh0120, 16'shFE40, 16'sh00C0, 16'sh0040, \
	16'shFFA0, 16'sh0200, 16'shFF00, 16'sh0080, 16'shFFE0, \
	16'sh0100, 16'shFF00, 16'sh0080, 16'shFF80, 16'sh0040, \
	16'shFFC0, 16'sh0020, 16'shFFE0, 16'sh0010, 16'shFFF0, \
	16'sh00D8, 16'shFF28, 16'sh0064, 16'shFF9C, 16'sh01C0, \
	16'shFE40, 16'sh0030, 16'shFFD0, 16'sh0150, 16'shFEB0 \
}

// hidden bias, neuron 3 first.
`define MLP_HID_BIAS { \
	16'sh00D8, 16'shFF00, 16'sh0040, 16'sh0000 \
}

// output weights, row 2 input 3 first.
`define MLP_OUT_WEIGHTS { \
	16'sh0180, 16'shFF40, 16'sh0100, 16'shFF80, \
	16'shFF00, 16'sh0200, 16'sh0080, 16'sh0040, \
	16'sh0100, 16'sh0100, 16'shFF00, 16'sh00C0 \
}

// output bias, neuron 2 first.
`define MLP_OUT_BIAS { \
	16'sh0000, 16'sh0020, 16'shFFE0 \
}

`endif

// File: hdl/mlpPkg.sv
`default_nettype none

`include "mlpCore_params.svh"

package mlpPkg;

	typedef logic signed [`MLP_DATA_W-1:0] sample_t; // q8.8 word.
	typedef logic signed [`MLP_ACC_W-1:0] acc_t;
	typedef logic [$clog2(`MLP_N_OUT)-1:0] classIdx_t;

	// vectors between the stages.
	typedef sample_t [`MLP_N_IN-1:0] inVec_t;
	typedef sample_t [`MLP_N_HID-1:0] hidVec_t;
	typedef sample_t [`MLP_N_OUT-1:0] scoreVec_t;

	// weight tables, one row per neuron.
	typedef sample_t [`MLP_N_HID-1:0][`MLP_N_IN-1:0] hidWeights_t;
	typedef sample_t [`MLP_N_OUT-1:0][`MLP_N_HID-1:0] outWeights_t;

	localparam acc_t SAT_MAX = acc_t'((1 <<< (`MLP_DATA_W - 1)) - 1);
	localparam acc_t SAT_MIN = -SAT_MAX - 1;

	// Drops the fraction bits of a product sum and clamps it to one sample.
	function automatic sample_t satShift(acc_t sum);
		acc_t shifted;
		shifted = sum >>> `MLP_FRAC; // floor, not truncation toward zero.
		if (shifted > SAT_MAX)
		begin
			return sample_t'(SAT_MAX);
		end
		else if (shifted < SAT_MIN)
		begin
			return sample_t'(SAT_MIN);
		end
		return sample_t'(shifted);
	endfunction

endpackage

`default_nettype wire

// File: hdl/neuron.sv
`default_nettype none

`include "mlpCore_params.svh"

module neuron #(
	parameter int N_IN = `MLP_N_IN,
	parameter mlpPkg::sample_t [N_IN-1:0] WEIGHTS = '0,
	parameter mlpPkg::sample_t BIAS = '0,
	parameter bit USE_RELU = 1'b1
) (
	input logic clk,
	input logic reset,
	input mlpPkg::sample_t [N_IN-1:0] inVec,
	output mlpPkg::sample_t result
);

	mlpPkg::sample_t [N_IN-1:0] inReg; // stage 1.
	mlpPkg::sample_t satReg; // stage 2.
	mlpPkg::acc_t sum;

	// stage 1, capture the input vector.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '0;
		end
		else
		begin
			inReg <= inVec;
		end
	end

	// Products are exact in 32 bits; the running sum wraps like the
	// accumulator it models.
	always_comb
	begin
		sum = mlpPkg::acc_t'($signed(BIAS)) <<< `MLP_FRAC; // bias in product scale.
		for (int i = 0; i < N_IN; i++)
		begin
			sum += mlpPkg::acc_t'($signed(inReg[i])) * mlpPkg::acc_t'($signed(WEIGHTS[i]));
		end
	end

	// stage 2, scale back to q8.8 and clamp.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			satReg <= '0;
		end
		else
		begin
			satReg <= mlpPkg::satShift(sum);
		end
	end

	// stage 3, activation.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else if (USE_RELU && satReg < 0)
		begin
			result <= '0; // rectifier clamp.
		end
		else
		begin
			result <= satReg;
		end
	end

endmodule

`default_nettype wire

// File: hdl/denseLayer.sv
`default_nettype none

`include "mlpCore_params.svh"

module denseLayer #(
	parameter int N_IN = `MLP_N_IN,
	parameter int N_OUT = `MLP_N_HID,
	parameter mlpPkg::sample_t [N_OUT-1:0][N_IN-1:0] WEIGHTS = '0,
	parameter mlpPkg::sample_t [N_OUT-1:0] BIAS = '0,
	parameter bit USE_RELU = 1'b1
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input mlpPkg::sample_t [N_IN-1:0] inVec,
	output logic outValid,
	output mlpPkg::sample_t [N_OUT-1:0] outVec
);

	logic [`MLP_LAYER_LAT-1:0] validPipe; // one bit per neuron stage.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[`MLP_LAYER_LAT-2:0], inValid};
		end
	end

	assign outValid = validPipe[`MLP_LAYER_LAT-1];

	// Every neuron sees the same vector and gets its own row and bias.
	generate
		for (genvar j = 0; j < N_OUT; j++)
		begin : genNeuron
			neuron #(
				.N_IN(N_IN),
				.WEIGHTS(WEIGHTS[j]),
				.BIAS(BIAS[j]),
				.USE_RELU(USE_RELU)
			) node (
				.clk(clk),
				.reset(reset),
				.inVec(inVec),
				.result(outVec[j])
			);
		end
	endgenerate

endmodule

`default_nettype wire

// File: hdl/argMax.sv
`default_nettype none

`include "mlpCore_params.svh"

module argMax #(
	parameter int N = `MLP_N_OUT
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input mlpPkg::sample_t [N-1:0] scores,
	output logic outValid,
	output mlpPkg::sample_t [N-1:0] scoresOut,
	output mlpPkg::classIdx_t classIdx
);

	mlpPkg::classIdx_t bestIdx;
	mlpPkg::sample_t bestVal;

	// strict compare keeps the lowest index on a tie.
	always_comb
	begin
		bestIdx = '0;
		bestVal = scores[0];
		for (int i = 1; i < N; i++)
		begin
			if ($signed(scores[i]) > $signed(bestVal))
			begin
				bestIdx = mlpPkg::classIdx_t'(i);
				bestVal = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= inValid;
		end
	end

	// results hold until the next strobe.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scoresOut <= '0;
			classIdx <= '0;
		end
		else if (inValid)
		begin
			scoresOut <= scores;
			classIdx <= bestIdx;
		end
	end

endmodule

`default_nettype wire

// File: hdl/mlpCore.sv
`default_nettype none

`include "mlpCore_params.svh"

module mlpCore (
	input logic clk,
	input logic reset,
	input logic inValid,
	input mlpPkg::inVec_t inVec,
	output logic outValid,
	output mlpPkg::scoreVec_t scores,
	output mlpPkg::classIdx_t classIdx
);

	localparam mlpPkg::hidWeights_t HID_WEIGHTS = `MLP_HID_WEIGHTS;
	localparam mlpPkg::hidVec_t HID_BIAS = `MLP_HID_BIAS;
	localparam mlpPkg::outWeights_t OUT_WEIGHTS = `MLP_OUT_WEIGHTS;
	localparam mlpPkg::scoreVec_t OUT_BIAS = `MLP_OUT_BIAS;

	logic hidValid;
	mlpPkg::hidVec_t hidVec;
	logic rawValid;
	mlpPkg::scoreVec_t rawScores; // linear outputs before arg-max.

	denseLayer #(
		.N_IN(`MLP_N_IN),
		.N_OUT(`MLP_N_HID),
		.WEIGHTS(HID_WEIGHTS),
		.BIAS(HID_BIAS),
		.USE_RELU(1'b1)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inVec(inVec),
		.outValid(hidValid),
		.outVec(hidVec)
	);

	// no rectifier on the scores.
	denseLayer #(
		.N_IN(`MLP_N_HID),
		.N_OUT(`MLP_N_OUT),
		.WEIGHTS(OUT_WEIGHTS),
		.BIAS(OUT_BIAS),
		.USE_RELU(1'b0)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inValid(hidValid),
		.inVec(hidVec),
		.outValid(rawValid),
		.outVec(rawScores)
	);

	argMax #(
		.N(`MLP_N_OUT)
	) picker (
		.clk(clk),
		.reset(reset),
		.inValid(rawValid),
		.scores(rawScores),
		.outValid(outValid),
		.scoresOut(scores),
		.classIdx(classIdx)
	);

endmodule

`default_nettype wire

// File: verif/mlpCore_checker.sv
`default_nettype none

`include "mlpCore_params.svh"

module mlpCore_checker (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic outValid,
	input mlpPkg::classIdx_t classIdx
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [2:0] settle; // edges since reset, stops at 7.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			settle <= '0;
		end
		else if (settle != 3'd7)
		begin
			settle <= settle + 3'd1;
		end
	end

	quietAfterReset: assert property (@(posedge clk) reset |=> !outValid)
		else $error("outValid high during reset or right after it");

	// Only once the whole 7 edge window lies after reset.
	fixedLatency: assert property (@(posedge clk) disable iff (reset)
		(settle == 3'd7) |-> (outValid == $past(inValid, 7)))
		else $error("outValid does not follow inValid by 7 cycles");

	legalClass: assert property (@(posedge clk) disable iff (reset)
		outValid |-> (classIdx < `MLP_N_OUT))
		else $error("classIdx out of range");

endmodule

bind mlpCore mlpCore_checker chk (
	.clk(clk),
	.reset(reset),
	.inValid(inValid),
	.outValid(outValid),
	.classIdx(classIdx)
);

`default_nettype wire

// File: verif/mlpCore_tb.sv
`default_nettype none

`include "mlpCore_params.svh"

module mlpCore_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam mlpPkg::hidWeights_t HID_W = `MLP_HID_WEIGHTS;
	localparam mlpPkg::hidVec_t HID_B = `MLP_HID_BIAS;
	localparam mlpPkg::outWeights_t OUT_W = `MLP_OUT_WEIGHTS;
	localparam mlpPkg::scoreVec_t OUT_B = `MLP_OUT_BIAS;

	logic clk;
	logic reset;
	logic inValid;
	mlpPkg::inVec_t inVec;
	logic outValid;
	mlpPkg::scoreVec_t scores;
	mlpPkg::classIdx_t classIdx;

	mlpPkg::scoreVec_t expScores[$];
	mlpPkg::classIdx_t expClass[$];
	int expEdge[$]; // edgeCount at which outValid must be seen.
	int edgeCount = 0;

	mlpCore UUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inVec(inVec),
		.outValid(outValid),
		.scores(scores),
		.classIdx(classIdx)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		edgeCount <= edgeCount + 1;
	end

	// floor shift back to q8.8, then clamp to 16 bits.
	function automatic mlpPkg::sample_t clampQ(int total);
		int scaled;
		scaled = total >>> `MLP_FRAC;
		if (scaled > 32767)
		begin
			return 16'sh7FFF;
		end
		if (scaled < -32768)
		begin
			return 16'sh8000;
		end
		return mlpPkg::sample_t'(scaled);
	endfunction

	function automatic void predict(input mlpPkg::inVec_t x, output mlpPkg::scoreVec_t s,
		output mlpPkg::classIdx_t c);
		mlpPkg::hidVec_t h;
		mlpPkg::sample_t best;
		int acc;
		for (int j = 0; j < `MLP_N_HID; j++)
		begin
			acc = int'($signed(HID_B[j])) <<< `MLP_FRAC;
			for (int i = 0; i < `MLP_N_IN; i++)
			begin
				acc += int'($signed(x[i])) * int'($signed(HID_W[j][i]));
			end
			h[j] = clampQ(acc);
			if ($signed(h[j]) < 0)
			begin
				h[j] = '0; // relu.
			end
		end
		best = 16'sh8000;
		for (int k = 0; k < `MLP_N_OUT; k++)
		begin
			acc = int'($signed(OUT_B[k])) <<< `MLP_FRAC;
			for (int j = 0; j < `MLP_N_HID; j++)
			begin
				acc += int'($signed(h[j])) * int'($signed(OUT_W[k][j]));
			end
			s[k] = clampQ(acc);
			if ($signed(s[k]) > $signed(best))
			begin
				best = s[k];
			end
		end
		c = '0;
		for (int k = `MLP_N_OUT - 1; k >= 0; k--)
		begin
			if (s[k] == best)
			begin
				c = mlpPkg::classIdx_t'(k); // lowest index ends up last.
			end
		end
	endfunction

	function automatic int tiedWinners(mlpPkg::inVec_t x);
		mlpPkg::scoreVec_t s;
		mlpPkg::classIdx_t c;
		int n;
		predict(x, s, c);
		n = 0;
		for (int k = 0; k < `MLP_N_OUT; k++)
		begin
			if (s[k] == s[c])
			begin
				n++;
			end
		end
		return n;
	endfunction

	// 0 moderate, 1 near the limits, 2 against the signs of one hidden row.
	function automatic mlpPkg::inVec_t makeVector(int mode);
		mlpPkg::inVec_t x;
		int row;
		int mag;
		row = int'($urandom_range(`MLP_N_HID - 1));
		for (int i = 0; i < `MLP_N_IN; i++)
		begin
			mag = int'($urandom_range(255));
			if (mode == 1)
			begin
				x[i] = $urandom_range(1) ? mlpPkg::sample_t'(32767 - mag)
					: mlpPkg::sample_t'(mag - 32768);
			end
			else if (mode == 2)
			begin
				mag = int'($urandom_range(4095)) + 1024;
				x[i] = mlpPkg::sample_t'($signed(HID_W[row][i]) < 0 ? mag : -mag);
			end
			else
			begin
				x[i] = mlpPkg::sample_t'(int'($urandom_range(8191)) - 4096);
			end
		end
		return x;
	endfunction

	task automatic checkValue(input int got, input int exp, input string what);
		if (got != exp)
		begin
			$display("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "check mismatch");
		end
	endtask

	// call at a rising edge.
	task automatic pushVector(input mlpPkg::inVec_t x);
		mlpPkg::scoreVec_t s;
		mlpPkg::classIdx_t c;
		predict(x, s, c);
		inValid <= 1'b1;
		inVec <= x;
		expScores.push_back(s);
		expClass.push_back(c);
		expEdge.push_back(edgeCount + 8);
		@(posedge clk);
	endtask

	task automatic stopInput();
		inValid <= 1'b0;
		@(posedge clk);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (expClass.size() != 0)
		begin
			@(posedge clk);
			waited++;
			if (waited > 50)
			begin
				$display("timeout: outValid never arrived for %0d vectors", expClass.size());
				$display("Test failures found");
				$fatal(1, "timeout");
			end
		end
	endtask

	task automatic applyReset();
		reset <= 1'b1;
		inValid <= 1'b0;
		expScores.delete();
		expClass.delete();
		expEdge.delete();
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	endtask

	always @(negedge clk)
	begin : monitor
		mlpPkg::scoreVec_t want;
		if (!reset && outValid)
		begin
			if (expClass.size() == 0)
			begin
				$display("outValid arrived at %0t with no vector pending", $time);
				$display("Test failures found");
				$fatal(1, "unexpected outValid");
			end
			else
			begin
				want = expScores.pop_front();
				for (int k = 0; k < `MLP_N_OUT; k++)
				begin
					checkValue(int'($signed(scores[k])), int'($signed(want[k])), "score");
				end
				checkValue(int'(classIdx), int'(expClass.pop_front()), "classIdx");
				checkValue(edgeCount, expEdge.pop_front(), "outValid edge");
			end
		end
	end

	initial
	begin
		mlpPkg::inVec_t v;
		int found;
		void'($urandom(32'h6e55));
		reset = 1'b1;
		inValid = 1'b0;
		inVec = '0;
		found = 0;
		applyReset();
		repeat (20)
		begin
			pushVector(makeVector(0));
			stopInput();
			drain();
		end
		repeat (200) pushVector(makeVector(0)); // seven in flight at a time.
		stopInput();
		drain();
		for (int mode = 1; mode <= 2; mode++)
		begin
			repeat (40) pushVector(makeVector(mode));
			stopInput();
			drain();
		end
		pushVector('0);
		for (int n = 0; n < 2000 && found < 12; n++)
		begin
			v = makeVector(1);
			if (tiedWinners(v) > 1)
			begin
				pushVector(v);
				found++;
			end
		end
		stopInput();
		drain();
		repeat (10) pushVector(makeVector(0)); // results already coming out.
		applyReset(); // drops the vectors still in flight.
		repeat (12) @(posedge clk);
		repeat (10) pushVector(makeVector(0));
		stopInput();
		drain();
		if (found == 0)
		begin
			$display("no input vector with tied output scores was found");
			$display("Test failures found");
			$fatal(1, "tie search");
		end
		else
		begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: mlpCore.f
+incdir+hdl
hdl/mlpPkg.sv
hdl/neuron.sv
hdl/denseLayer.sv
hdl/argMax.sv
hdl/mlpCore.sv
verif/mlpCore_checker.sv
verif/mlpCore_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps -f mlpCore.f \
	--top-module mlpCore_tb -o mlpCore_sim > build.log 2>&1 \
	&& ./obj_dir/mlpCore_sim > sim.log 2>&1
grep -qsx "All tests passed!" sim.log && echo "PASS" \
	|| { echo "FAIL, see build.log and sim.log"; exit 1; }
